/* sources.f */
verilog/fpPkg.sv
verilog/Unpack.sv
verilog/MantissaAlu.sv
verilog/Normalize.sv
verilog/FpAdder.sv
sim/fpChecker.sv
sim/tbFpAdder.sv

/* run.sh */
#!/bin/sh
# Build and run the floating-point adder testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tbFpAdder -f sources.f -o simFpAdder
output=$(./obj_dir/simFpAdder)
echo "$output"
if echo "$output" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

/* sim/tbFpAdder.sv */
// Testbench top for the pipelined floating-point adder with random bursts per test
`timescale 1ns/10ps

module tbFpAdder import fpPkg::*;
();
    localparam int clkPeriod = 4;
    localparam int numTests = 5;
    localparam int slotsPerTest = 60;
    // Issue slots plus drain and report cycles per test and the reset
    localparam int watchdogCycles = numTests * (slotsPerTest + 8) + 20;

    logic        clk = 1'b0;
    logic        reset;
    logic        start;
    logic [31:0] opA;
    logic [31:0] opB;
    fpOpE        op;
    logic        done;
    logic [31:0] result;
    int          testId;
    logic        testEnd;
    int          pending;
    int          checkCount;
    int          errorCount;
    int          issued;

    always #(clkPeriod / 2) clk = ~clk;

    FpAdder u_dut
    (
        .clk(clk),
        .reset(reset),
        .start(start),
        .opA(opA),
        .opB(opB),
        .op(op),
        .done(done),
        .result(result)
    );

    fpChecker fpCheck
    (
        .clk(clk),
        .reset(reset),
        .start(start),
        .opA(opA),
        .opB(opB),
        .op(op),
        .done(done),
        .result(result),
        .testId(testId),
        .testEnd(testEnd),
        .pending(pending),
        .checkCount(checkCount),
        .errorCount(errorCount)
    );

    function automatic logic [31:0] normalOperand(input int exponent);
        return {1'($urandom), 8'(exponent), 23'($urandom)};
    endfunction

    task automatic makeOperands(input int id);
        int          e;
        logic [31:0] mask;
        e = 100 + int'($urandom % 50);
        op = ($urandom % 2 == 1) ? fpOpSub : fpOpAdd;
        case (id)
            0:
            begin
                opA = normalOperand(e);
                opB = normalOperand(e - 3 + int'($urandom % 7));
            end
            1:
            begin
                // Low fraction bits differ, signs arranged to cancel
                mask = (32'h1 << ($urandom % 24)) - 1;
                if ($urandom % 4 == 0)
                    mask = '0;
                opA = normalOperand(e);
                opB = opA ^ (mask & $urandom);
                if (op == fpOpAdd)
                    opB[31] = ~opA[31];
            end
            2:
            begin
                opA = normalOperand(e);
                opB = normalOperand(e - int'($urandom % 40));
            end
            3:
            begin
                opA = normalOperand(expMax - 1);
                opB = normalOperand(expMax - 1 - int'($urandom % 2));
                opB[31] = opA[31] ^ (op == fpOpSub);
            end
            default:
            begin
                // Exponent 0 with a stray fraction reads as zero
                opA = normalOperand(e);
                opB = {1'($urandom), 8'h00, 23'($urandom)};
                if ($urandom % 2 == 1)
                    {opA, opB} = {opB, opA};
            end
        endcase
    endtask

    task automatic runTest(input int id);
        int slot;
        testId = id;
        for (slot = 0; slot < slotsPerTest; slot++)
        begin
            @(posedge clk);
            #1;
            start = ($urandom % 4 != 0);
            makeOperands(id);
            if (start)
                issued++;
        end
        @(posedge clk);
        #1;
        start = 1'b0;
        while (pending != 0)
            @(posedge clk);
        #1;
        testEnd = 1'b1;
        @(posedge clk);
        #1;
        testEnd = 1'b0;
    endtask

    initial
    begin
        int id;
        void'($urandom(32'hdb88));
        reset = 1'b1;
        start = 1'b0;
        opA = '0;
        opB = '0;
        op = fpOpAdd;
        testId = 0;
        testEnd = 1'b0;
        issued = 0;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        for (id = 0; id < numTests; id++)
            runTest(id);
        $display("Summary: %0d operations, %0d checks, %0d errors",
                 issued, checkCount, errorCount);
        if (errorCount == 0 && checkCount == issued)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

    initial
    begin
        #(watchdogCycles * clkPeriod);
        $display("Watchdog expired before all tests finished");
        $display("Testbench failed");
        $finish;
    end

endmodule

/* sim/fpChecker.sv */
// Scoreboard for the floating-point adder that models each operation and checks its result
`timescale 1ns/10ps

module fpChecker import fpPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    input  fpOpE        op,
    input  logic        done,
    input  logic [31:0] result,
    input  int          testId,
    input  logic        testEnd,
    output int          pending,
    output int          checkCount,
    output int          errorCount
);
    logic [31:0] expectQ[$];
    int          dueQ[$];
    int          cycle = 0;
    int          testChecks;
    int          testErrors;

    function automatic string testLabel(input int id);
        case (id)
            0: return "closeExponents";
            1: return "cancellation";
            2: return "rounding";
            3: return "overflow";
            default: return "zeroInputs";
        endcase
    endfunction

    // Reference sum with guard, round and sticky kept beside the significand
    function automatic logic [31:0] expectedSum(input logic [31:0] a, input logic [31:0] b,
                                                input fpOpE opSel);
        logic [31:0]         bx;
        logic [31:0]         hi;
        logic [31:0]         lo;
        logic [sigWidth-1:0] big;
        logic [sigWidth-1:0] smallSig;
        logic [sigWidth:0]   sum;
        logic [manWidth:0]   frac;
        logic                sub;
        logic                g;
        logic                r;
        logic                s;
        int                  e;
        int                  i;
        // Subtraction is addition of the negated second operand
        bx = {b[31] ^ (opSel == fpOpSub), b[30:0]};
        hi = (bx[30:0] > a[30:0]) ? bx : a;
        lo = (bx[30:0] > a[30:0]) ? a : bx;
        big = (hi[30:23] == 8'd0) ? '0 : {1'b1, hi[22:0]};
        smallSig = (lo[30:23] == 8'd0) ? '0 : {1'b1, lo[22:0]};
        e = int'(hi[30:23]);
        g = 1'b0;
        r = 1'b0;
        s = 1'b0;
        for (i = 0; i < e - int'(lo[30:23]); i++)
        begin
            s = s | r;
            r = g;
            g = smallSig[0];
            smallSig = smallSig >> 1;
        end
        sub = hi[31] ^ lo[31];
        sum = sub ? {1'b0, big} - {1'b0, smallSig} : {1'b0, big} + {1'b0, smallSig};
        if (sum == '0)
            return {hi[31] & ~sub, 31'b0};
        if (sum[sigWidth])
        begin
            s = s | r;
            r = g;
            g = sum[0];
            sum = sum >> 1;
            e = e + 1;
            if (e >= expMax)
                return {hi[31], 8'(expMax), 23'b0};
        end
        else
        begin
            i = 0;
            while (!sum[sigWidth-1])
            begin
                sum = {sum[sigWidth-1:0], g};
                g = r;
                r = s;
                s = 1'b0;
                i = i + 1;
            end
            e = (e > i) ? e - i : 0;
        end
        frac = {1'b0, sum[manWidth-1:0]} + {23'b0, g & (r | s | sum[0])};
        if (frac[manWidth])
        begin
            e = e + 1;
            if (e >= expMax)
                return {hi[31], 8'(expMax), 23'b0};
        end
        return {hi[31], 8'(e), frac[manWidth-1:0]};
    endfunction

    task automatic noteError();
        testErrors++;
        errorCount++;
    endtask

    always @(posedge clk)
        cycle <= cycle + 1;

    // Inputs change just after the rising edge and are stable here
    always @(negedge clk)
    begin
        if (reset)
        begin
            checkCount = 0;
            errorCount = 0;
            testChecks = 0;
            testErrors = 0;
            expectQ.delete();
            dueQ.delete();
        end
        else
        begin
            if (done && expectQ.size() == 0)
            begin
                $display("Error in %s: done pulsed with no operation in flight",
                         testLabel(testId));
                noteError();
            end
            else if (done)
            begin
                if (dueQ[0] != cycle)
                begin
                    $display("Error in %s: done came at cycle %0d instead of cycle %0d",
                             testLabel(testId), cycle, dueQ[0]);
                    noteError();
                end
                else if (result !== expectQ[0])
                begin
                    $display("Mismatch in %s: expected %h, actual %h",
                             testLabel(testId), expectQ[0], result);
                    noteError();
                end
                checkCount++;
                testChecks++;
                expectQ.delete(0);
                dueQ.delete(0);
            end
            else if (expectQ.size() != 0 && dueQ[0] <= cycle)
            begin
                $display("Error in %s: no done for the result due at cycle %0d",
                         testLabel(testId), dueQ[0]);
                noteError();
                expectQ.delete(0);
                dueQ.delete(0);
            end
            // Accepted at the next edge, visible here two samples later
            if (start)
            begin
                expectQ.push_back(expectedSum(opA, opB, op));
                dueQ.push_back(cycle + 2);
            end
            if (testEnd)
            begin
                $display("Test %s finished: %0d checks, %0d errors",
                         testLabel(testId), testChecks, testErrors);
                testChecks = 0;
                testErrors = 0;
            end
        end
        pending = expectQ.size();
    end

endmodule

/* verilog/FpAdder.sv */
// Two-stage pipelined single-precision floating-point add and subtract unit
`timescale 1ns/10ps

module FpAdder import fpPkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start,
    input  logic [31:0] opA,
    input  logic [31:0] opB,
    input  fpOpE        op,
    output logic        done,
    output logic [31:0] result
);
    logic [sigWidth-1:0] upBigMantissa;
    logic [sigWidth-1:0] upSmallMantissa;
    logic [expWidth-1:0] upExponent;
    logic                upBigSign;
    logic                upEffSub;
    logic                upGuard;
    logic                upRound;
    logic                upSticky;

    logic                s1Valid;
    logic [sigWidth-1:0] s1BigMantissa;
    logic [sigWidth-1:0] s1SmallMantissa;
    logic [expWidth-1:0] s1Exponent;
    logic                s1BigSign;
    logic                s1EffSub;
    logic                s1Guard;
    logic                s1Round;
    logic                s1Sticky;

    logic [sigWidth-1:0] aluResult;
    logic                aluCarry;
    logic                aluSign;

    logic                normSign;
    logic [expWidth-1:0] normExponent;
    logic [manWidth-1:0] normMantissa;

    Unpack uUnpack
    (
        .opA(opA),
        .opB(opB),
        .op(op),
        .bigMantissa(upBigMantissa),
        .smallMantissa(upSmallMantissa),
        .exponentOut(upExponent),
        .bigSign(upBigSign),
        .smallSign(),
        .effSub(upEffSub),
        .guardBit(upGuard),
        .roundBit(upRound),
        .stickyBit(upSticky)
    );

    // Stage 1 valid
    always_ff @(posedge clk)
    begin
        if (reset)
            s1Valid <= 1'b0;
        else
            s1Valid <= start;
    end

    // Stage 1 payload loaded per accepted operation
    always_ff @(posedge clk)
    begin
        if (start)
        begin
            s1BigMantissa <= upBigMantissa;
            s1SmallMantissa <= upSmallMantissa;
            s1Exponent <= upExponent;
            s1BigSign <= upBigSign;
            s1EffSub <= upEffSub;
            s1Guard <= upGuard;
            s1Round <= upRound;
            s1Sticky <= upSticky;
        end
    end

    MantissaAlu uAlu
    (
        .bigMantissa(s1BigMantissa),
        .smallMantissa(s1SmallMantissa),
        .bigSign(s1BigSign),
        .effSub(s1EffSub),
        .alignedResult(aluResult),
        .carryOut(aluCarry),
        .alignedSign(aluSign)
    );

    Normalize uNormalize
    (
        .alignedResult(aluResult),
        .carryOut(aluCarry),
        .alignedSign(aluSign),
        .guardBit(s1Guard),
        .roundBit(s1Round),
        .stickyBit(s1Sticky),
        .exponentOut(s1Exponent),
        .normalizedSign(normSign),
        .normalizedExponent(normExponent),
        .normalizedMantissa(normMantissa)
    );

    // Output register and done strobe
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            done <= 1'b0;
            result <= '0;
        end
        else
        begin
            done <= s1Valid;
            if (s1Valid)
                result <= {normSign, normExponent, normMantissa};
        end
    end

endmodule

/* verilog/Normalize.sv */
// Result normalizer with overflow clamp and round to nearest even
`timescale 1ns/10ps

module Normalize import fpPkg::*;
(
    input  logic [sigWidth-1:0] alignedResult,
    input  logic                carryOut,
    input  logic                alignedSign,
    input  logic                guardBit,
    input  logic                roundBit,
    input  logic                stickyBit,
    input  logic [expWidth-1:0] exponentOut,
    output logic                normalizedSign,
    output logic [expWidth-1:0] normalizedExponent,
    output logic [manWidth-1:0] normalizedMantissa
);
    logic [4:0]          zeroCount;
    logic [sigWidth+2:0] work;
    logic [expWidth:0]   expWork;
    logic [expWidth:0]   expBumped;
    logic                overflow;
    logic                roundUp;
    logic [manWidth:0]   roundedMantissa;

    // Leading zeros of the 24-bit significand, 24 when all clear
    function automatic logic [4:0] countZeros(input logic [sigWidth-1:0] value);
        logic [4:0] count;
        int         i;
        count = 5'(sigWidth);
        for (i = 0; i < sigWidth; i++)
        begin
            if (value[i])
                count = 5'(sigWidth - 1 - i);
        end
        return count;
    endfunction

    assign zeroCount = countZeros(alignedResult);

    // Significand followed by guard, round and sticky
    always_comb
    begin
        if (carryOut)
        begin
            // Shift right by one, the dropped LSB becomes guard
            work = {carryOut, alignedResult, guardBit, roundBit | stickyBit};
            expWork = {1'b0, exponentOut} + 1'b1;
            overflow = (expWork >= expMax);
        end
        else
        begin
            work = {alignedResult, guardBit, roundBit, stickyBit} << zeroCount;
            overflow = 1'b0;
            // Underflow clamps at 0 and leaves the shifted fraction
            if ({1'b0, exponentOut} > {4'b0, zeroCount})
                expWork = {1'b0, exponentOut} - {4'b0, zeroCount};
            else
                expWork = '0;
        end
    end

    // Up when guard is set and round, sticky or LSB is set
    assign roundUp = work[2] & (work[1] | work[0] | work[3]);
    assign roundedMantissa = {1'b0, work[manWidth+2:3]} + roundUp;
    assign expBumped = expWork + 1'b1;

    always_comb
    begin
        normalizedSign = alignedSign;
        if (!carryOut && alignedResult == '0)
        begin
            normalizedExponent = '0;
            normalizedMantissa = '0;
        end
        else if (overflow)
        begin
            normalizedExponent = expWidth'(expMax);
            normalizedMantissa = '0;
        end
        else if (roundedMantissa[manWidth])
        begin
            // Rounding carried out of the fraction
            normalizedMantissa = '0;
            if (expBumped >= expMax)
                normalizedExponent = expWidth'(expMax);
            else
                normalizedExponent = expBumped[expWidth-1:0];
        end
        else
        begin
            normalizedExponent = expWork[expWidth-1:0];
            normalizedMantissa = roundedMantissa[manWidth-1:0];
        end
    end

endmodule

/* verilog/MantissaAlu.sv */
// Significand adder and subtractor for the aligned operands
`timescale 1ns/10ps

module MantissaAlu import fpPkg::*;
(
    input  logic [sigWidth-1:0] bigMantissa,
    input  logic [sigWidth-1:0] smallMantissa,
    input  logic                bigSign,
    input  logic                effSub,
    output logic [sigWidth-1:0] alignedResult,
    output logic                carryOut,
    output logic                alignedSign
);
    logic [sigWidth:0] sum;
    logic              exactZero;

    // One extra bit holds the carry of an addition
    always_comb
    begin
        if (effSub)
            sum = {1'b0, bigMantissa} - {1'b0, smallMantissa};
        else
            sum = {1'b0, bigMantissa} + {1'b0, smallMantissa};
    end

    // Operand ordering keeps the difference non-negative,
    // so the top bit is only ever set by an addition
    assign carryOut = sum[sigWidth];
    assign alignedResult = sum[sigWidth-1:0];

    assign exactZero = (sum == '0);

    // Cancellation yields +0
    always_comb
    begin
        if (effSub && exactZero)
            alignedSign = 1'b0;
        else
            alignedSign = bigSign;
    end

endmodule

/* verilog/Unpack.sv */
// Operand unpack stage that orders the operands by magnitude and aligns the smaller one
`timescale 1ns/10ps

module Unpack import fpPkg::*;
(
    input  logic [31:0]         opA,
    input  logic [31:0]         opB,
    input  fpOpE                op,
    output logic [sigWidth-1:0] bigMantissa,
    output logic [sigWidth-1:0] smallMantissa,
    output logic [expWidth-1:0] exponentOut,
    output logic                bigSign,
    output logic                smallSign,
    output logic                effSub,
    output logic                guardBit,
    output logic                roundBit,
    output logic                stickyBit
);
    logic [expWidth-1:0]     expA;
    logic [expWidth-1:0]     expB;
    logic [sigWidth-1:0]     sigA;
    logic [sigWidth-1:0]     sigB;
    logic                    signA;
    logic                    signB;
    logic                    aIsBig;
    logic [expWidth-1:0]     smallExp;
    logic [sigWidth-1:0]     smallSig;
    logic [expWidth-1:0]     expDiff;
    logic [2*sigWidth-1:0]   alignExt;

    // Field split, subnormals flushed to a zero significand
    assign expA = opA[manWidth +: expWidth];
    assign expB = opB[manWidth +: expWidth];
    assign sigA = (expA == '0) ? '0 : {1'b1, opA[manWidth-1:0]};
    assign sigB = (expB == '0) ? '0 : {1'b1, opB[manWidth-1:0]};
    assign signA = opA[expWidth+manWidth];

    // B is the subtrahend
    assign signB = opB[expWidth+manWidth] ^ (op == fpOpSub);

    // Exponent and significand compared as one magnitude
    assign aIsBig = {expA, sigA} >= {expB, sigB};

    always_comb
    begin
        if (aIsBig)
        begin
            exponentOut = expA;
            bigMantissa = sigA;
            bigSign = signA;
            smallExp = expB;
            smallSig = sigB;
            smallSign = signB;
        end
        else
        begin
            exponentOut = expB;
            bigMantissa = sigB;
            bigSign = signB;
            smallExp = expA;
            smallSig = sigA;
            smallSign = signA;
        end
    end

    assign effSub = signA ^ signB;
    assign expDiff = exponentOut - smallExp;

    // Lower half of the extension catches the bits shifted out
    assign alignExt = {smallSig, {sigWidth{1'b0}}} >> expDiff;

    assign smallMantissa = alignExt[2*sigWidth-1 -: sigWidth];
    assign guardBit = alignExt[sigWidth-1];
    assign roundBit = alignExt[sigWidth-2];

    // Beyond the extension everything lands in sticky
    always_comb
    begin
        if (expDiff >= expWidth'(2 * sigWidth))
            stickyBit = |smallSig;
        else
            stickyBit = |alignExt[sigWidth-3:0];
    end

endmodule

/* verilog/fpPkg.sv */
// Shared opcode type and IEEE-754 single-precision field widths for the adder
package fpPkg;

    // Requested operation, one bit wide
    typedef enum logic
    {
        fpOpAdd = 1'b0,
        fpOpSub = 1'b1
    } fpOpE;

    // Biased exponent field
    localparam int expWidth = 8;

    // Stored fraction without the hidden bit
    localparam int manWidth = 23;

    // Significand including the hidden 1
    localparam int sigWidth = manWidth + 1;

    // Saturation exponent used on overflow
    localparam int expMax = 255;

endpackage
